/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_branch_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+hdl
hdl/hsv_core_pkg.sv
hdl/hsv_core_decode_pkg.sv
hdl/hsv_core_decode_common.sv
hdl/hsv_core_decode_branch.sv
hdl/hsv_core_decode.sv
hdl/hsv_core_branch_exec.sv
hdl/hsv_core_branch_unit.sv
tests/branch_unit_checker.sv
tests/tb_branch_unit.sv

/* hdl/hsv_core_branch_exec.sv */
`timescale 1ns/1ps

`include "hsv_core_defs.svh"

module hsv_core_branch_exec (
    input  logic                                clk_core,
    input  logic                                rst_i,
    input  hsv_core_decode_pkg::decode_out_t    decode_i,
    output hsv_core_decode_pkg::branch_result_t result_o
);

    logic              equal;
    logic              less;
    logic              cond_true;
    logic              taken;
    logic              active;
    hsv_core_pkg::word base;
    hsv_core_pkg::word taken_target;
    hsv_core_pkg::word next_pc;

    always_comb begin
        equal = decode_i.rs1_value == decode_i.rs2_value;
        if (decode_i.branch.cond_signed) begin
            less = $signed(decode_i.rs1_value) < $signed(decode_i.rs2_value);
        end else begin
            less = decode_i.rs1_value < decode_i.rs2_value;
        end

        if (decode_i.branch.cond == hsv_core_decode_pkg::BRANCH_COND_EQUAL) begin
            cond_true = equal;
        end else begin
            cond_true = less;
        end
        taken = decode_i.branch.unconditional | (cond_true ^ decode_i.branch.negate);

        // jalr adds to rs1 and drops bit 0
        base         = decode_i.branch.relative ? decode_i.common.pc : decode_i.rs1_value;
        taken_target = base + decode_i.common.immediate;
        if (!decode_i.branch.relative) begin
            taken_target[0] = 1'b0;
        end

        next_pc = taken ? taken_target : decode_i.common.pc_increment;
    end

    assign active = decode_i.valid & ~decode_i.illegal;

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            result_o.valid    <= 1'b0;
            result_o.redirect <= 1'b0;
            result_o.link     <= 1'b0;
            result_o.target   <= `HSV_RESET_PC;
        end else begin
            result_o.valid    <= decode_i.valid;
            result_o.redirect <= active & (next_pc != decode_i.branch.predicted);
            result_o.link     <= active & decode_i.branch.link;
            result_o.target   <= next_pc;
        end
        result_o.illegal    <= decode_i.illegal;
        result_o.rd         <= decode_i.common.rd;
        result_o.link_value <= decode_i.common.pc_increment;
    end

endmodule

/* hdl/hsv_core_branch_unit.sv */
`timescale 1ns/1ps

module hsv_core_branch_unit (
    input  logic                                clk_core,
    input  logic                                rst_i,
    input  logic                                valid_i,
    input  hsv_core_pkg::word                   insn_i,
    input  hsv_core_pkg::word                   pc_i,
    input  hsv_core_pkg::word                   rs1_value_i,
    input  hsv_core_pkg::word                   rs2_value_i,
    output hsv_core_decode_pkg::branch_result_t result_o
);

    // between decode and execute
    hsv_core_decode_pkg::decode_out_t decode;

    hsv_core_decode u_decode (
        .clk_core    (clk_core),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .insn_i      (insn_i),
        .pc_i        (pc_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .decode_o    (decode)
    );

    hsv_core_branch_exec u_exec (
        .clk_core (clk_core),
        .rst_i    (rst_i),
        .decode_i (decode),
        .result_o (result_o)
    );

endmodule

/* hdl/hsv_core_decode.sv */
`timescale 1ns/1ps

module hsv_core_decode (
    input  logic                             clk_core,
    input  logic                             rst_i,
    input  logic                             valid_i,
    input  hsv_core_pkg::word                insn_i,
    input  hsv_core_pkg::word                pc_i,
    input  hsv_core_pkg::word                rs1_value_i,
    input  hsv_core_pkg::word                rs2_value_i,
    output hsv_core_decode_pkg::decode_out_t decode_o
);

    hsv_core_decode_pkg::decode_common_t common_all;
    hsv_core_decode_pkg::common_data_t   common_sel;
    hsv_core_decode_pkg::branch_data_t   branch_data;
    logic                                illegal;

    // fields for every format, picked below by opcode
    hsv_core_decode_common u_common (
        .insn_i   (insn_i),
        .pc_i     (pc_i),
        .common_o (common_all)
    );

    hsv_core_decode_branch u_branch (
        .insn_i        (insn_i),
        .common_i      (common_all),
        .branch_data_o (branch_data),
        .common_o      (common_sel),
        .illegal_o     (illegal)
    );

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            decode_o.valid <= 1'b0;
        end else begin
            decode_o.valid <= valid_i;
        end

        // payload only moves with a valid instruction
        if (valid_i) begin
            decode_o.illegal   <= illegal;
            decode_o.common    <= common_sel;
            decode_o.branch    <= branch_data;
            decode_o.rs1_value <= rs1_value_i;
            decode_o.rs2_value <= rs2_value_i;
        end
    end

endmodule

/* hdl/hsv_core_decode_branch.sv */
`timescale 1ns/1ps

module hsv_core_decode_branch (
    input  hsv_core_pkg::word                   insn_i,
    input  hsv_core_decode_pkg::decode_common_t common_i,
    output hsv_core_decode_pkg::branch_data_t   branch_data_o,
    output hsv_core_decode_pkg::common_data_t   common_o,
    output logic                                illegal_o
);

    always_comb begin
        illegal_o = 1'b0;
        common_o  = 'x;

        branch_data_o          = '0;
        branch_data_o.relative = 1'b1;

        unique casez ({hsv_core_pkg::rv_major_op(insn_i), hsv_core_pkg::rv_funct3_op(insn_i)})
            // jal, funct3 is part of the offset
            {hsv_core_pkg::RV_MAJOR_JAL, hsv_core_pkg::RvFunct3Any}: begin
                common_o                    = common_i.j_type;
                branch_data_o.link          = 1'b1;
                branch_data_o.unconditional = 1'b1;
            end

            // jalr, base is rs1
            {hsv_core_pkg::RV_MAJOR_JALR, hsv_core_pkg::RvFunct3Null}: begin
                common_o                    = common_i.i_type;
                branch_data_o.link          = 1'b1;
                branch_data_o.relative      = 1'b0;
                branch_data_o.unconditional = 1'b1;
            end

            // beq
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBeq}: begin
                common_o           = common_i.b_type;
                branch_data_o.cond = hsv_core_decode_pkg::BRANCH_COND_EQUAL;
            end

            // bne
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBne}: begin
                common_o             = common_i.b_type;
                branch_data_o.cond   = hsv_core_decode_pkg::BRANCH_COND_EQUAL;
                branch_data_o.negate = 1'b1;
            end

            // blt
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBlt}: begin
                common_o                  = common_i.b_type;
                branch_data_o.cond        = hsv_core_decode_pkg::BRANCH_COND_LESS_THAN;
                branch_data_o.cond_signed = 1'b1;
            end

            // bge is not blt
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBge}: begin
                common_o                  = common_i.b_type;
                branch_data_o.cond        = hsv_core_decode_pkg::BRANCH_COND_LESS_THAN;
                branch_data_o.negate      = 1'b1;
                branch_data_o.cond_signed = 1'b1;
            end

            // bltu
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBltu}: begin
                common_o           = common_i.b_type;
                branch_data_o.cond = hsv_core_decode_pkg::BRANCH_COND_LESS_THAN;
            end

            // bgeu is not bltu
            {hsv_core_pkg::RV_MAJOR_BRANCH, hsv_core_pkg::RvFunct3BranchBgeu}: begin
                common_o             = common_i.b_type;
                branch_data_o.cond   = hsv_core_decode_pkg::BRANCH_COND_LESS_THAN;
                branch_data_o.negate = 1'b1;
            end

            default: illegal_o = 1'b1;
        endcase

        // static not-taken prediction, jumps included
        branch_data_o.predicted = common_o.pc_increment;

        // signedness means nothing for an equality test
        unique case (branch_data_o.cond)
            hsv_core_decode_pkg::BRANCH_COND_EQUAL: branch_data_o.cond_signed = 'x;
            default: ;
        endcase

        // jumps ignore the comparator entirely
        if (branch_data_o.unconditional) begin
            branch_data_o.cond        = hsv_core_decode_pkg::branch_cond_t'('x);
            branch_data_o.negate      = 'x;
            branch_data_o.cond_signed = 'x;
        end

        if (illegal_o) begin
            common_o      = 'x;
            branch_data_o = 'x;
        end
    end

endmodule

/* hdl/hsv_core_decode_common.sv */
`timescale 1ns/1ps

`include "hsv_core_defs.svh"

module hsv_core_decode_common (
    input  hsv_core_pkg::word                   insn_i,
    input  hsv_core_pkg::word                   pc_i,
    output hsv_core_decode_pkg::decode_common_t common_o
);

    hsv_core_pkg::rv_insn_t insn;
    hsv_core_pkg::word      pc_next;

    assign insn    = insn_i;
    assign pc_next = pc_i + `HSV_XLEN'(`HSV_ILEN);

    always_comb begin
        // i-type, used by jalr
        common_o.i_type.pc           = pc_i;
        common_o.i_type.pc_increment = pc_next;
        common_o.i_type.immediate    = {{20{insn.i_view.imm[11]}}, insn.i_view.imm};
        common_o.i_type.rs1          = insn.i_view.rs1;
        common_o.i_type.rs2          = '0;
        common_o.i_type.rd           = insn.i_view.rd;

        // j-type, offset in multiples of two
        common_o.j_type.pc           = pc_i;
        common_o.j_type.pc_increment = pc_next;
        common_o.j_type.immediate    = {{11{insn.j_view.imm_20}}, insn.j_view.imm_20,
                                        insn.j_view.imm_19_12, insn.j_view.imm_11,
                                        insn.j_view.imm_10_1, 1'b0};
        common_o.j_type.rs1          = '0;
        common_o.j_type.rs2          = '0;
        common_o.j_type.rd           = insn.j_view.rd;

        // b-type, no destination register
        common_o.b_type.pc           = pc_i;
        common_o.b_type.pc_increment = pc_next;
        common_o.b_type.immediate    = {{19{insn.b_view.imm_12}}, insn.b_view.imm_12,
                                        insn.b_view.imm_11, insn.b_view.imm_10_5,
                                        insn.b_view.imm_4_1, 1'b0};
        common_o.b_type.rs1          = insn.b_view.rs1;
        common_o.b_type.rs2          = insn.b_view.rs2;
        common_o.b_type.rd           = '0;
    end

endmodule

/* hdl/hsv_core_decode_pkg.sv */
package hsv_core_decode_pkg;

    // fields shared by all formats once decoded
    typedef struct packed {
        hsv_core_pkg::word pc;
        hsv_core_pkg::word pc_increment;
        hsv_core_pkg::word immediate;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
    } common_data_t;

    // one entry per instruction format
    typedef struct packed {
        common_data_t i_type;
        common_data_t j_type;
        common_data_t b_type;
    } decode_common_t;

    typedef enum logic {
        BRANCH_COND_EQUAL,
        BRANCH_COND_LESS_THAN
    } branch_cond_t;

    typedef struct packed {
        hsv_core_pkg::word predicted;
        branch_cond_t      cond;
        logic              negate;
        logic              cond_signed;
        logic              relative;
        logic              link;
        logic              unconditional;
    } branch_data_t;

    // decode stage register contents
    typedef struct packed {
        logic              valid;
        logic              illegal;
        common_data_t      common;
        branch_data_t      branch;
        hsv_core_pkg::word rs1_value;
        hsv_core_pkg::word rs2_value;
    } decode_out_t;

    // resolved branch, redirect and link only meaningful with valid
    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic              redirect;
        hsv_core_pkg::word target;
        logic              link;
        logic [4:0]        rd;
        hsv_core_pkg::word link_value;
    } branch_result_t;

endpackage

/* hdl/hsv_core_defs.svh */
`ifndef HSV_CORE_DEFS_SVH
`define HSV_CORE_DEFS_SVH

// data and address width
`define HSV_XLEN 32

// instruction length in bytes, also the sequential pc step
`define HSV_ILEN 4

// pc value seen after reset
`define HSV_RESET_PC 32'h0000_0000

`endif

/* hdl/hsv_core_pkg.sv */
`include "hsv_core_defs.svh"

package hsv_core_pkg;

    typedef logic [`HSV_XLEN-1:0] word;

    // opcode bits 6:2, the low two bits are always 2'b11 for 32-bit encodings
    typedef enum logic [4:0] {
        RV_MAJOR_LOAD     = 5'b00000,
        RV_MAJOR_MISC_MEM = 5'b00011,
        RV_MAJOR_OP_IMM   = 5'b00100,
        RV_MAJOR_AUIPC    = 5'b00101,
        RV_MAJOR_STORE    = 5'b01000,
        RV_MAJOR_OP       = 5'b01100,
        RV_MAJOR_LUI      = 5'b01101,
        RV_MAJOR_BRANCH   = 5'b11000,
        RV_MAJOR_JALR     = 5'b11001,
        RV_MAJOR_JAL      = 5'b11011,
        RV_MAJOR_SYSTEM   = 5'b11100
    } rv_major_op_t;

    typedef logic [2:0] rv_funct3_t;

    localparam rv_funct3_t RvFunct3Null       = 3'b000;
    localparam rv_funct3_t RvFunct3Any        = 3'b???;
    localparam rv_funct3_t RvFunct3BranchBeq  = 3'b000;
    localparam rv_funct3_t RvFunct3BranchBne  = 3'b001;
    localparam rv_funct3_t RvFunct3BranchBlt  = 3'b100;
    localparam rv_funct3_t RvFunct3BranchBge  = 3'b101;
    localparam rv_funct3_t RvFunct3BranchBltu = 3'b110;
    localparam rv_funct3_t RvFunct3BranchBgeu = 3'b111;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        rv_funct3_t  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    // branch offset is scattered, bit 0 is implied zero
    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        rv_funct3_t  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } rv_b_view_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_j_view_t;

    typedef union packed {
        rv_i_view_t i_view;
        rv_b_view_t b_view;
        rv_j_view_t j_view;
    } rv_insn_t;

    function automatic rv_major_op_t rv_major_op(word insn);
        rv_insn_t fields;
        fields = insn;
        return rv_major_op_t'(fields.i_view.opcode[6:2]);
    endfunction

    // funct3 sits at the same place in every format that has it
    function automatic rv_funct3_t rv_funct3_op(word insn);
        rv_insn_t fields;
        fields = insn;
        return fields.i_view.funct3;
    endfunction

endpackage

/* tests/branch_unit_checker.sv */
`timescale 1ns/1ps

module branch_unit_checker (
    input logic                                clk_core,
    input logic                                rst_i,
    input logic                                valid_i,
    input hsv_core_pkg::word                   insn_i,
    input hsv_core_pkg::word                   pc_i,
    input hsv_core_pkg::word                   rs1_value_i,
    input hsv_core_pkg::word                   rs2_value_i,
    input hsv_core_decode_pkg::branch_result_t result_i
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    int unsigned error_count = 0;
    logic [1:0]  history     = 2'd0;

    hsv_core_decode_pkg::branch_result_t exp_now;
    hsv_core_decode_pkg::branch_result_t exp_q1;
    hsv_core_decode_pkg::branch_result_t exp_q2;

    // reference resolution straight from the instruction bits
    function automatic hsv_core_decode_pkg::branch_result_t model_branch(
        input hsv_core_pkg::word insn, pc, a, b);
        hsv_core_decode_pkg::branch_result_t r;
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic              taken;
        logic              legal;
        hsv_core_pkg::word dest;
        hsv_core_pkg::word seq_pc;

        opc    = insn[6:0];
        f3     = insn[14:12];
        seq_pc = pc + 32'd4;
        taken  = 1'b0;
        legal  = 1'b1;
        dest   = seq_pc;
        r      = '0;
        if (opc == OPC_JAL) begin
            taken = 1'b1;
            dest  = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        end else if (opc == OPC_JALR && f3 == 3'b000) begin
            taken = 1'b1;
            dest  = (a + {{20{insn[31]}}, insn[31:20]}) & ~32'd1;
        end else if (opc == OPC_BRANCH) begin
            case (f3)
                3'b000:  taken = a == b;
                3'b001:  taken = a != b;
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                3'b111:  taken = a >= b;
                default: legal = 1'b0;
            endcase
            dest = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end else begin
            legal = 1'b0;
        end
        r.illegal    = !legal;
        r.target     = taken ? dest : seq_pc;
        r.redirect   = legal && (r.target != seq_pc);
        r.link       = legal && (opc == OPC_JAL || opc == OPC_JALR);
        r.rd         = insn[11:7];
        r.link_value = seq_pc;
        return r;
    endfunction

    assign exp_now = model_branch(insn_i, pc_i, rs1_value_i, rs2_value_i);

    // two stages, lined up with the DUT result
    always @(posedge clk_core) begin
        exp_q1 <= exp_now;
        exp_q2 <= exp_q1;
        if (history != 2'd3) begin
            history <= history + 2'd1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk_core)
        rst_i |=> !result_i.valid && !result_i.redirect && !result_i.link)
        else begin
            error_count++;
            $error("result strobes were not cleared by reset");
        end

    a_valid_latency: assert property (@(posedge clk_core) history[1] |->
        result_i.valid == ($past(valid_i, 2) && !$past(rst_i) && !$past(rst_i, 2)))
        else begin
            error_count++;
            $error("mismatch result_o.valid got %h expected %h",
                   $sampled(result_i.valid), !$sampled(result_i.valid));
        end

    a_idle_quiet: assert property (@(posedge clk_core)
        history[1] && !result_i.valid |-> !result_i.redirect && !result_i.link)
        else begin
            error_count++;
            $error("redirect or link raised without a valid result");
        end

    a_illegal: assert property (@(posedge clk_core)
        history[1] && result_i.valid |-> result_i.illegal == exp_q2.illegal)
        else begin
            error_count++;
            $error("mismatch result_o.illegal got %h expected %h",
                   $sampled(result_i.illegal), $sampled(exp_q2.illegal));
        end

    a_redirect: assert property (@(posedge clk_core)
        history[1] && result_i.valid |-> result_i.redirect == exp_q2.redirect)
        else begin
            error_count++;
            $error("mismatch result_o.redirect got %h expected %h",
                   $sampled(result_i.redirect), $sampled(exp_q2.redirect));
        end

    // not-taken results carry pc plus 4 as target
    a_target: assert property (@(posedge clk_core)
        history[1] && result_i.valid && !exp_q2.illegal |-> result_i.target == exp_q2.target)
        else begin
            error_count++;
            $error("mismatch result_o.target got %h expected %h",
                   $sampled(result_i.target), $sampled(exp_q2.target));
        end

    a_link: assert property (@(posedge clk_core)
        history[1] && result_i.valid |-> result_i.link == exp_q2.link)
        else begin
            error_count++;
            $error("mismatch result_o.link got %h expected %h",
                   $sampled(result_i.link), $sampled(exp_q2.link));
        end

    a_link_data: assert property (@(posedge clk_core)
        history[1] && result_i.valid && exp_q2.link |->
        {result_i.rd, result_i.link_value} == {exp_q2.rd, exp_q2.link_value})
        else begin
            error_count++;
            $error("mismatch result_o.rd/link_value got %h/%h expected %h/%h",
                   $sampled(result_i.rd), $sampled(result_i.link_value),
                   $sampled(exp_q2.rd), $sampled(exp_q2.link_value));
        end

endmodule

/* tests/tb_branch_unit.sv */
`timescale 1ns/1ps

module tb_branch_unit;

    localparam int RESET_CYCLES = 16;
    localparam int STIM_CYCLES  = 400;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + STIM_CYCLES + 10;

    logic                                clk_core = 1'b0;
    logic                                rst_i;
    logic                                valid_i;
    hsv_core_pkg::word                   insn_i;
    hsv_core_pkg::word                   pc_i;
    hsv_core_pkg::word                   rs1_value_i;
    hsv_core_pkg::word                   rs2_value_i;
    hsv_core_decode_pkg::branch_result_t result_o;

    logic [31:0] lfsr_state = 32'd71;
    int          cycles     = 0;
    int          sent       = 0;
    int          received   = 0;

    always #20 clk_core = ~clk_core;

    hsv_core_branch_unit u_dut (
        .clk_core    (clk_core),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .insn_i      (insn_i),
        .pc_i        (pc_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .result_o    (result_o)
    );

    bind hsv_core_branch_unit branch_unit_checker u_checker (
        .clk_core    (clk_core),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .insn_i      (insn_i),
        .pc_i        (pc_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .result_i    (result_o)
    );

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // slots 12 and up hold illegal {opcode, funct3} pairs
    function automatic logic [9:0] encoding(input logic [3:0] slot);
        case (slot)
            4'd0, 4'd10: return {7'b1101111, 3'b000};
            4'd1, 4'd11: return {7'b1100111, 3'b000};
            4'd2, 4'd8:  return {7'b1100011, 3'b000};
            4'd3, 4'd9:  return {7'b1100011, 3'b001};
            4'd4:        return {7'b1100011, 3'b100};
            4'd5:        return {7'b1100011, 3'b101};
            4'd6:        return {7'b1100011, 3'b110};
            4'd7:        return {7'b1100011, 3'b111};
            4'd12:       return {7'b1100011, 3'b010};
            4'd13:       return {7'b1100011, 3'b011};
            4'd14:       return {7'b1100111, 3'b001};
            default:     return {7'b0110011, 3'b000};
        endcase
    endfunction

    task automatic drive_slot();
        logic [31:0] slot;
        logic [31:0] upper;
        logic [31:0] rd;
        logic [31:0] pc_bits;
        logic [31:0] f3_bits;
        logic [9:0]  enc;
        logic [2:0]  funct3;
        slot        = draw_bits(4);
        enc         = encoding(slot[3:0]);
        valid_i     = |draw_bits(2);
        upper       = draw_bits(17);
        rd          = draw_bits(5);
        funct3      = enc[2:0];
        // jal keeps offset bits where other formats have funct3
        if (enc[9:3] == 7'b1101111) begin
            f3_bits = draw_bits(3);
            funct3  = f3_bits[2:0];
        end
        insn_i      = {upper[16:0], funct3, rd[4:0], enc[9:3]};
        pc_bits     = draw_bits(30);
        pc_i        = {pc_bits[29:0], 2'b00};
        rs1_value_i = draw_bits(32);
        // equal operands a quarter of the time so beq and bne get taken
        rs2_value_i = (draw_bits(2) == 32'd0) ? rs1_value_i : draw_bits(32);
        if (valid_i) begin
            sent++;
        end
    endtask

    always @(posedge clk_core) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("FAIL: see errors above");
            $fatal(1, "timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(negedge clk_core) begin
        if (result_o.valid === 1'b1) begin
            received++;
        end
        if (u_dut.u_checker.error_count != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first assertion failure");
        end
    end

    initial begin
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        insn_i      = '0;
        pc_i        = '0;
        rs1_value_i = '0;
        rs2_value_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_core);
        rst_i = 1'b0;
        // one quiet cycle keeps results low for two cycles after reset
        @(negedge clk_core);
        repeat (STIM_CYCLES) begin
            drive_slot();
            @(negedge clk_core);
        end
        valid_i = 1'b0;
        wait (received == sent);
        @(negedge clk_core);
        if (u_dut.u_checker.error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures found");
        end
    end

endmodule
